//--- dv/aesEncryptTb.sv
`timescale 1ns/1ns
`include "aes_macros.svh"

module aesEncryptTb
  import aesDataPkg::*;
();

  localparam int NUM_VECTORS = 6;
  localparam int LATENCY = `AES_NUM_ROUNDS;
  localparam int TIMEOUT_CYCLES = NUM_VECTORS * 14 + 50;

  typedef struct packed {
    aesBlockT plainText;
    aesKeyT   key;
    aesBlockT expected;
    logic     stray;
  } vectorT;

  logic clk;
  logic arstN;
  logic start;
  aesBlockT plainText;
  aesKeyT cipherKey;
  logic busy;
  logic done;
  aesBlockT cipherText;

  vectorT vectors [NUM_VECTORS];
  logic [31:0] rngState;
  int errCount;
  int failedTests;
  int cycleCount;

  aesEncryptCore uut (
    .clk        (clk),
    .arstN      (arstN),
    .start      (start),
    .plainText  (plainText),
    .cipherKey  (cipherKey),
    .busy       (busy),
    .done       (done),
    .cipherText (cipherText)
  );

  bind aesEncryptCore aesEncryptProps uProps (
    .clk   (clk),
    .arstN (arstN),
    .start (start),
    .busy  (busy),
    .done  (done)
  );

  // *********************************************************************
  // Helpers
  // *********************************************************************

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic randomBlock(output aesBlockT b);
    for (int k = 0; k < 4; k++)
    begin
      rngState = xorshift32(rngState);
      b[127 - 32*k -: 32] = rngState;
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    assert (got === exp)
    else
    begin
      $display("error: %s got %0h expected %0h", name, got, exp);
      errCount++;
    end
  endtask

  task automatic checkBlock(input string name, input aesBlockT got, input aesBlockT exp);
    assert (got === exp)
    else
    begin
      $display("error: %s got %h expected %h", name, got, exp);
      errCount++;
    end
  endtask

  // Known answers from FIPS-197, Appendix C.1 and B, and the all-zero case.
  task automatic loadVectors();
    aesKeyT keyC1;
    aesKeyT keyB;
    aesBlockT ptC1;
    aesBlockT ptB;
    keyC1 = 128'h000102030405060708090a0b0c0d0e0f;
    ptC1 = 128'h00112233445566778899aabbccddeeff;
    keyB = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    ptB = 128'h3243f6a8885a308d313198a2e0370734;
    vectors[0] = {ptC1, keyC1, 128'h69c4e0d86a7b0430d8cdb78070b4c55a, 1'b0};
    vectors[1] = {ptB, keyB, 128'h3925841d02dc09fbdc118597196a0b32, 1'b1};
    vectors[2] = {128'h0, 128'h0, 128'h66e94bd4ef8a2c3b884cfa59ca342b2e, 1'b0};
    vectors[3] = {ptC1, keyC1, 128'h69c4e0d86a7b0430d8cdb78070b4c55a, 1'b1};
    vectors[4] = {128'h0, 128'h0, 128'h66e94bd4ef8a2c3b884cfa59ca342b2e, 1'b1};
    vectors[5] = {ptB, keyB, 128'h3925841d02dc09fbdc118597196a0b32, 1'b0};
  endtask

  // *********************************************************************
  // Clock and timeout
  // *********************************************************************

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial
  begin
    cycleCount = 0;
    while (cycleCount < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycleCount++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // *********************************************************************
  // Stimulus
  // *********************************************************************

  initial
  begin
    int latency;
    int strayAt;
    int errBefore;
    logic gotDone;
    aesBlockT prevResult;
    start = 1'b0;
    plainText = '0;
    cipherKey = '0;
    arstN = 1'b0;
    rngState = 32'hb17c11bc;
    errCount = 0;
    failedTests = 0;
    loadVectors();
    repeat (2) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;
    checkBit("busy", busy, 1'b0);
    checkBit("done", done, 1'b0);
    checkBlock("cipherText", cipherText, '0);
    if (errCount != 0)
    begin
      failedTests++;
    end
    $display("reset: %s", errCount == 0 ? "ok" : "failed");
    prevResult = '0;

    for (int i = 0; i < NUM_VECTORS; i++)
    begin
      // For every entry after the first this is the cycle where done is high.
      errBefore = errCount;
      start = 1'b1;
      plainText = vectors[i].plainText;
      cipherKey = vectors[i].key;
      strayAt = -1;
      if (vectors[i].stray)
      begin
        rngState = xorshift32(rngState);
        strayAt = int'(rngState % 32'd9) + 1;
      end
      // Counts rising edges since the accepting edge, so the first falling edge reads 0.
      latency = -1;
      gotDone = 1'b0;
      while (!gotDone && latency < 2 * LATENCY)
      begin
        @(negedge clk);
        latency++;
        start = 1'b0;
        if (done)
        begin
          gotDone = 1'b1;
          assert (latency == LATENCY)
          else
          begin
            $display("error: latency got %0h expected %0h", latency, LATENCY);
            errCount++;
          end
          checkBit("busy", busy, 1'b0);
          checkBlock("cipherText", cipherText, vectors[i].expected);
        end
        else
        begin
          checkBit("busy", busy, 1'b1);
          checkBlock("cipherText", cipherText, prevResult);
          // Sampled at the next edge while the core is still busy.
          if (latency == strayAt)
          begin
            start = 1'b1;
            randomBlock(plainText);
            randomBlock(cipherKey);
          end
        end
      end
      assert (gotDone)
      else
      begin
        $display("test %0d: done never rose within %0d cycles", i, 2 * LATENCY);
        errCount++;
      end
      prevResult = vectors[i].expected;
      if (errCount != errBefore)
      begin
        failedTests++;
      end
      $display("test %0d: %s, latency %0d, stray start cycle %0d", i,
               errCount == errBefore ? "ok" : "failed", latency, strayAt);
    end

    // The last result stays on the output once done has dropped.
    errBefore = errCount;
    @(negedge clk);
    checkBit("done", done, 1'b0);
    checkBit("busy", busy, 1'b0);
    checkBlock("cipherText", cipherText, prevResult);
    if (errCount != errBefore)
    begin
      failedTests++;
    end
    $display("hold: %s", errCount == errBefore ? "ok" : "failed");

    $display("tests %0d, failed %0d, errors %0d", NUM_VECTORS + 2, failedTests, errCount);
    if (errCount == 0)
    begin
      $display("*** TEST PASSED ***");
    end
    else
    begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- dv/aesEncrypt_props.sv
`timescale 1ns/1ns

module aesEncryptProps
(
  input logic clk,
  input logic arstN,
  input logic start,
  input logic busy,
  input logic done
);

  // *********************************************************************
  // Control handshake
  // *********************************************************************

  // A finished block reports done for a single cycle.
  doneOneCycle: assert property (@(posedge clk) disable iff (!arstN)
    done |=> !done)
    else $error("done stayed high for more than one cycle");

  // An accepted start puts the core to work on the next cycle.
  busyAfterStart: assert property (@(posedge clk) disable iff (!arstN)
    (start && !busy) |=> busy)
    else $error("busy did not rise after an accepted start");

  // Done and the end of busy come together.
  doneWithBusyFall: assert property (@(posedge clk) disable iff (!arstN)
    $rose(done) |-> $fell(busy))
    else $error("done rose without busy falling in the same cycle");

endmodule

//--- flist.f
+incdir+src
src/aesDataPkg.sv
src/aesCtrlPkg.sv
src/sboxRom.sv
src/roundDatapath.sv
src/keyExpander.sv
src/aesEncryptCore.sv
dv/aesEncrypt_props.sv
dv/aesEncryptTb.sv

//--- run.sh
#!/bin/sh
# Compile and run the AES-128 testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module aesEncryptTb -f flist.f -o aesEncryptSim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/aesEncryptSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\*\* TEST PASSED \*\*\*$' "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- src/aesCtrlPkg.sv
`include "aes_macros.svh"

package aesCtrlPkg;

  // Wide enough for round numbers 0 to AES_NUM_ROUNDS.
  typedef logic [$clog2(`AES_NUM_ROUNDS + 1)-1:0] roundCountT;

  typedef enum logic {
    IDLE,
    RUN
  } ctrlStateT;

endpackage

//--- src/aesDataPkg.sv
`include "aes_macros.svh"

package aesDataPkg;

  typedef logic [7:0] aesByteT;
  typedef logic [31:0] aesWordT;
  typedef logic [`AES_BLOCK_BITS-1:0] aesBlockT;
  typedef logic [`AES_KEY_BITS-1:0] aesKeyT;

  // One round of work for the round datapath.
  typedef struct packed {
    aesBlockT state;
    aesKeyT roundKey;
    logic lastRound;
  } roundCmdT;

  // Multiply by x in GF(2^8).
  function automatic aesByteT xtime(aesByteT b);
    return {b[6:0], 1'b0} ^ (b[7] ? `AES_GF_POLY : 8'h00);
  endfunction

endpackage

//--- src/aesEncryptCore.sv
`timescale 1ns/1ns
`include "aes_macros.svh"

module aesEncryptCore import aesDataPkg::*, aesCtrlPkg::*;
(
  input  logic     clk,
  input  logic     arstN,
  input  logic     start,
  input  aesBlockT plainText,
  input  aesKeyT   cipherKey,
  output logic     busy,
  output logic     done,
  output aesBlockT cipherText
);

  localparam roundCountT LAST_ROUND = roundCountT'(`AES_NUM_ROUNDS);

  ctrlStateT ctrlState;
  roundCountT roundCnt;
  aesBlockT stateReg;
  aesBlockT nextState;
  aesKeyT roundKey;
  roundCmdT cmd;
  logic accept;
  logic finalRound;

  assign busy = (ctrlState == RUN);

  // Start is honoured only while idle.
  assign accept = start && !busy;
  assign finalRound = (roundCnt == LAST_ROUND);

  // *********************************************************************
  // Datapath
  // *********************************************************************

  keyExpander uKeyExpander (
    .clk       (clk),
    .arstN     (arstN),
    .load      (accept),
    .advance   (busy),
    .cipherKey (cipherKey),
    .roundKey  (roundKey)
  );

  assign cmd.state = stateReg;
  assign cmd.roundKey = roundKey;
  assign cmd.lastRound = finalRound;

  roundDatapath uRound (
    .cmd       (cmd),
    .nextState (nextState)
  );

  // The initial AddRoundKey happens on the accepting edge.
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      stateReg <= plainText ^ cipherKey;
    end
    else if (busy)
    begin
      stateReg <= nextState;
    end
  end

  // *********************************************************************
  // Controller
  // *********************************************************************

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      ctrlState <= IDLE;
      roundCnt <= '0;
      done <= 1'b0;
      cipherText <= '0;
    end
    else
    begin
      done <= 1'b0;
      case (ctrlState)
        IDLE:
        begin
          if (accept)
          begin
            ctrlState <= RUN;
            roundCnt <= roundCountT'(1);
          end
        end
        RUN:
        begin
          roundCnt <= roundCountT'(roundCnt + 1'b1);
          if (finalRound)
          begin
            // Round 10 result goes straight to the output register.
            ctrlState <= IDLE;
            roundCnt <= '0;
            done <= 1'b1;
            cipherText <= nextState;
          end
        end
        default:
        begin
          ctrlState <= IDLE;
        end
      endcase
    end
  end

endmodule

//--- src/aes_macros.svh
`ifndef AES_MACROS_SVH
`define AES_MACROS_SVH

// Data block and cipher key widths in bits.
`define AES_BLOCK_BITS 128
`define AES_KEY_BITS 128

// AES-128 runs ten rounds after the initial AddRoundKey.
`define AES_NUM_ROUNDS 10

// Round constant for the first expanded key.
`define AES_RCON_FIRST 8'h01

// Low byte of x^8 + x^4 + x^3 + x + 1, used by xtime and the rcon update.
`define AES_GF_POLY 8'h1B

`endif

//--- src/keyExpander.sv
`timescale 1ns/1ns
`include "aes_macros.svh"

module keyExpander import aesDataPkg::*;
(
  input  logic   clk,
  input  logic   arstN,
  input  logic   load,
  input  logic   advance,
  input  aesKeyT cipherKey,
  output aesKeyT roundKey
);

  aesKeyT keyReg;
  aesByteT rcon;
  aesWordT rotWord;
  wire aesWordT subWord;
  aesWordT schedTemp;
  aesWordT w0;
  aesWordT w1;
  aesWordT w2;
  aesWordT w3;

  // RotWord on the last word of the current key.
  assign rotWord = {keyReg[23:0], keyReg[31:24]};

  for (genvar i = 0; i < 4; i++)
  begin : gSubWord
    sboxRom uSbox (
      .dataIn  (rotWord[31 - 8*i -: 8]),
      .dataOut (subWord[31 - 8*i -: 8])
    );
  end

  assign schedTemp = subWord ^ {rcon, 24'h000000};

  // Each new word chains off the one before it.
  assign w0 = keyReg[127:96] ^ schedTemp;
  assign w1 = keyReg[95:64] ^ w0;
  assign w2 = keyReg[63:32] ^ w1;
  assign w3 = keyReg[31:0] ^ w2;

  assign roundKey = {w0, w1, w2, w3};

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      rcon <= '0;
    end
    else if (load)
    begin
      rcon <= `AES_RCON_FIRST;
    end
    else if (advance)
    begin
      rcon <= xtime(rcon);
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      keyReg <= cipherKey;
    end
    else if (advance)
    begin
      keyReg <= roundKey;
    end
  end

endmodule

//--- src/roundDatapath.sv
`timescale 1ns/1ns

module roundDatapath import aesDataPkg::*;
(
  input  roundCmdT cmd,
  output aesBlockT nextState
);

  wire aesByteT subB [16];
  aesBlockT shifted;
  aesBlockT mixed;

  function automatic aesWordT mixColumn(aesWordT col);
    aesByteT a0;
    aesByteT a1;
    aesByteT a2;
    aesByteT a3;
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    // 3*a is xtime(a) ^ a.
    return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
            xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
  endfunction

  // *********************************************************************
  // SubBytes
  // *********************************************************************

  for (genvar i = 0; i < 16; i++)
  begin : gSbox
    sboxRom uSbox (
      .dataIn  (cmd.state[127 - 8*i -: 8]),
      .dataOut (subB[i])
    );
  end

  // *********************************************************************
  // ShiftRows and MixColumns
  // *********************************************************************

  // Byte r of column c takes the byte of row r from column (c + r) mod 4.
  always_comb
  begin
    for (int c = 0; c < 4; c++)
    begin
      for (int r = 0; r < 4; r++)
      begin
        shifted[127 - 8*(4*c + r) -: 8] = subB[4*((c + r) % 4) + r];
      end
    end
  end

  always_comb
  begin
    for (int c = 0; c < 4; c++)
    begin
      mixed[127 - 32*c -: 32] = mixColumn(shifted[127 - 32*c -: 32]);
    end
  end

  // The final round skips MixColumns.
  assign nextState = (cmd.lastRound ? shifted : mixed) ^ cmd.roundKey;

endmodule

//--- src/sboxRom.sv
`timescale 1ns/1ns

module sboxRom import aesDataPkg::*;
(
  input  aesByteT dataIn,
  output aesByteT dataOut
);

  // Forward S-box, one row of sixteen entries per literal.
  localparam aesByteT [0:255] SBOX = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  assign dataOut = SBOX[dataIn];

endmodule
